/* design/soc_defs.svh */
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// System bus
`define SOC_DATA_W 32
`define SOC_ADDR_W 32
`define SOC_MASK_W (`SOC_DATA_W / 8)

// Data memory geometry
`define SOC_LANES 16
`define SOC_ROW_AW 10
`define SOC_MEM_DEPTH (1 << `SOC_ROW_AW)
`define SOC_ROW_W (`SOC_LANES * 8)
`define SOC_ROW_WORDS (`SOC_ROW_W / `SOC_DATA_W)

// Upper address nibble that selects the matrix engine
`define SOC_GEMM_REGION 4'h9

// Matrix engine
`define SOC_MAT_N 4
`define SOC_ELEM_W 8
`define SOC_ACC_W 32
`define SOC_REG_AW 5

`endif

/* design/soc_bus_pkg.sv */
package soc_bus_pkg;

  // Taken straight from the rdwr level of the host bus
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } bus_op_e;

  // Target picked by the upper address nibble
  typedef enum logic {
    region_mem  = 1'b0,
    region_gemm = 1'b1
  } region_e;

endpackage

/* design/gemm_pkg.sv */
`include "soc_defs.svh"

package gemm_pkg;

  typedef enum logic [2:0] {
    st_idle    = 3'd0,
    st_load_a  = 3'd1,
    st_load_b  = 3'd2,
    st_compute = 3'd3,
    st_finish  = 3'd4
  } gemm_state_e;

  // Byte offsets inside the engine region
  typedef enum logic [`SOC_REG_AW-1:0] {
    reg_ctrl   = 5'h00,
    reg_status = 5'h04,
    reg_a_base = 5'h08,
    reg_b_base = 5'h0C,
    reg_c_base = 5'h10
  } gemm_reg_e;

  typedef logic signed [`SOC_ELEM_W-1:0] elem_t;
  typedef logic signed [`SOC_ACC_W-1:0] acc_t;

  // Element [i][j] lands in byte 4i+j of a memory row
  typedef elem_t [`SOC_MAT_N-1:0][`SOC_MAT_N-1:0] mat_t;
  typedef acc_t [`SOC_MAT_N-1:0] c_row_t;

endpackage

/* design/bus_ifs.sv */
`timescale 1ns/1ps
`include "soc_defs.svh"

interface sys_bus_if;
  logic                   en;
  logic                   rdwr;  // 1 means write
  logic [`SOC_MASK_W-1:0] mask;
  logic [`SOC_ADDR_W-1:0] addr;
  logic [`SOC_DATA_W-1:0] wr_data;
  logic [`SOC_DATA_W-1:0] rd_data;  // Registered, valid the cycle after en

  modport master (
    output en,
    output rdwr,
    output mask,
    output addr,
    output wr_data,
    input  rd_data
  );

  modport slave (
    input  en,
    input  rdwr,
    input  mask,
    input  addr,
    input  wr_data,
    output rd_data
  );
endinterface

interface row_port_if;
  logic                      en;
  logic [`SOC_ROW_WORDS-1:0] we;  // One enable per 32-bit word
  logic [`SOC_ROW_AW-1:0]    row_addr;
  logic [`SOC_ROW_W-1:0]     wr_data;
  logic [`SOC_ROW_W-1:0]     rd_data;

  modport master (
    output en,
    output we,
    output row_addr,
    output wr_data,
    input  rd_data
  );

  modport slave (
    input  en,
    input  we,
    input  row_addr,
    input  wr_data,
    output rd_data
  );
endinterface

/* design/bus_decoder.sv */
`timescale 1ns/1ps
`include "soc_defs.svh"

module bus_decoder import soc_bus_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   bus_en,
  input  logic                   bus_rdwr,
  input  logic [`SOC_MASK_W-1:0] bus_mask,
  input  logic [`SOC_ADDR_W-1:0] bus_addr,
  input  logic [`SOC_DATA_W-1:0] bus_wr_data,
  output logic [`SOC_DATA_W-1:0] bus_rd_data,
  output logic                   bus_rd_valid,
  sys_bus_if.master              mem_bus,
  sys_bus_if.master              gemm_bus
);

  bus_op_e                op;
  region_e                region;
  region_e                region_q;
  logic                   rd_req;
  logic [`SOC_ADDR_W-1:0] word_addr;

  assign op        = bus_op_e'(bus_rdwr);
  assign region    = (bus_addr[`SOC_ADDR_W-1 -: 4] == `SOC_GEMM_REGION) ? region_gemm : region_mem;
  assign word_addr = {bus_addr[`SOC_ADDR_W-1:2], 2'b00};
  assign rd_req    = bus_en && (op == op_read);

  assign mem_bus.en      = bus_en && (region == region_mem);
  assign mem_bus.rdwr    = (op == op_write);
  assign mem_bus.mask    = bus_mask;
  assign mem_bus.addr    = word_addr;
  assign mem_bus.wr_data = bus_wr_data;

  assign gemm_bus.en      = bus_en && (region == region_gemm);
  assign gemm_bus.rdwr    = (op == op_write);
  assign gemm_bus.mask    = bus_mask;
  assign gemm_bus.addr    = word_addr;
  assign gemm_bus.wr_data = bus_wr_data;

  // Both targets register their read data, so the select is delayed to match
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus_rd_valid <= 1'b0;
      region_q     <= region_mem;
    end else begin
      bus_rd_valid <= rd_req;
      if (rd_req) begin
        region_q <= region;
      end
    end
  end

  assign bus_rd_data = (region_q == region_gemm) ? gemm_bus.rd_data : mem_bus.rd_data;

  a_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
    bus_en |-> !$isunknown(bus_addr))
    else $error("bus_addr has unknown bits during an access: %h", bus_addr);

endmodule

/* design/banked_memory.sv */
`timescale 1ns/1ps
`include "soc_defs.svh"

module banked_memory (
  input  logic       clk,
  sys_bus_if.slave   host,
  row_port_if.slave  row
);

  localparam int WORD_LANES = `SOC_DATA_W / 8;
  localparam int WORD_SEL_W = $clog2(`SOC_ROW_WORDS);

  logic [`SOC_ROW_AW-1:0]     host_row;
  logic [WORD_SEL_W-1:0]      host_word;
  logic [WORD_SEL_W-1:0]      host_word_q;
  logic                       host_rd;
  logic                       row_rd;
  logic [`SOC_LANES-1:0][7:0] host_rd_lanes;
  logic [`SOC_LANES-1:0][7:0] row_rd_lanes;

  assign host_row  = host.addr[`SOC_ROW_AW+3:4];
  assign host_word = host.addr[3:2];
  assign host_rd   = host.en && !host.rdwr;
  assign row_rd    = row.en && (row.we == '0);

  for (genvar l = 0; l < `SOC_LANES; l++) begin : g_lane
    localparam int WORD = l / WORD_LANES;
    localparam int BYTE = l % WORD_LANES;

    logic [7:0] ram [`SOC_MEM_DEPTH];
    logic [7:0] host_q;
    logic [7:0] row_q;
    logic       host_we;
    logic       row_we;

    assign host_we = host.en && host.rdwr && (host_word == WORD) && host.mask[BYTE];
    assign row_we  = row.en && row.we[WORD];

    always_ff @(posedge clk) begin
      if (row_we) begin
        ram[row.row_addr] <= row.wr_data[8*l +: 8];
      end else if (host_we) begin
        ram[host_row] <= host.wr_data[8*BYTE +: 8];
      end
      if (host_rd) begin
        host_q <= ram[host_row];
      end
      if (row_rd) begin
        row_q <= ram[row.row_addr];
      end
    end

    assign host_rd_lanes[l] = host_q;
    assign row_rd_lanes[l]  = row_q;
  end

  // Word select follows the lane data by one cycle
  always_ff @(posedge clk) begin
    if (host_rd) begin
      host_word_q <= host_word;
    end
  end

  assign host.rd_data = host_rd_lanes[{host_word_q, 2'b00} +: WORD_LANES];
  assign row.rd_data  = row_rd_lanes;

  // No arbitration here, the host has to stay away while the engine runs
  a_no_port_clash: assert property (@(posedge clk)
    host.en |-> !row.en)
    else $error("Host and row port access data memory in the same cycle");

endmodule

/* design/gemm_engine.sv */
`timescale 1ns/1ps
`include "soc_defs.svh"

module gemm_engine import gemm_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  sys_bus_if.slave   cfg,
  row_port_if.master row,
  output logic       irq
);

  localparam int IDX_W = $clog2(`SOC_MAT_N);

  gemm_state_e            state;
  gemm_reg_e              reg_sel;
  logic [IDX_W-1:0]       row_idx;
  logic [`SOC_DATA_W-1:0] a_base;
  logic [`SOC_DATA_W-1:0] b_base;
  logic [`SOC_DATA_W-1:0] c_base;
  logic                   busy;
  logic                   done;
  logic                   cfg_wr;
  logic                   cfg_rd;
  logic                   start;
  logic                   first_compute;
  mat_t                   a_mat;
  mat_t                   b_mat;
  mat_t                   b_cur;
  c_row_t                 c_row;

  function automatic logic [`SOC_DATA_W-1:0] merge_bytes(
    input logic [`SOC_DATA_W-1:0] cur,
    input logic [`SOC_DATA_W-1:0] data,
    input logic [`SOC_MASK_W-1:0] mask
  );
    logic [`SOC_DATA_W-1:0] res;
    res = cur;
    for (int i = 0; i < `SOC_MASK_W; i++) begin
      if (mask[i]) begin
        res[8*i +: 8] = data[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign reg_sel       = gemm_reg_e'(cfg.addr[`SOC_REG_AW-1:0]);
  assign cfg_wr        = cfg.en && cfg.rdwr;
  assign cfg_rd        = cfg.en && !cfg.rdwr;
  assign busy          = (state != st_idle);
  assign start         = cfg_wr && (reg_sel == reg_ctrl) && cfg.wr_data[0] && !busy;
  assign first_compute = (state == st_compute) && (row_idx == '0);
  assign irq           = (state == st_finish);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_idle;
      row_idx <= '0;
      done    <= 1'b0;
      a_base  <= '0;
      b_base  <= '0;
      c_base  <= '0;
    end else begin
      if (cfg_wr) begin
        case (reg_sel)
          reg_a_base: a_base <= merge_bytes(a_base, cfg.wr_data, cfg.mask);
          reg_b_base: b_base <= merge_bytes(b_base, cfg.wr_data, cfg.mask);
          reg_c_base: c_base <= merge_bytes(c_base, cfg.wr_data, cfg.mask);
          default: ;
        endcase
      end
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_load_a;
            done  <= 1'b0;  // Done stays set until the next accepted start
          end
        end
        st_load_a: state <= st_load_b;
        st_load_b: begin
          state   <= st_compute;
          row_idx <= '0;
        end
        st_compute: begin
          row_idx <= row_idx + 1'b1;
          if (row_idx == IDX_W'(`SOC_MAT_N - 1)) begin
            state <= st_finish;
          end
        end
        st_finish: begin
          state <= st_idle;
          done  <= 1'b1;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // A arrives during load_b, B on the first compute cycle
  always_ff @(posedge clk) begin
    if (state == st_load_b) begin
      a_mat <= mat_t'(row.rd_data);
    end
    if (first_compute) begin
      b_mat <= b_cur;
    end
  end

  always_comb begin
    acc_t sum;
    b_cur = first_compute ? mat_t'(row.rd_data) : b_mat;
    for (int j = 0; j < `SOC_MAT_N; j++) begin
      sum = '0;
      for (int k = 0; k < `SOC_MAT_N; k++) begin
        sum += acc_t'(signed'(a_mat[row_idx][k])) * acc_t'(signed'(b_cur[k][j]));
      end
      c_row[j] = sum;
    end
  end

  always_comb begin
    row.en       = 1'b0;
    row.we       = '0;
    row.row_addr = '0;
    row.wr_data  = c_row;
    case (state)
      st_load_a: begin
        row.en       = 1'b1;
        row.row_addr = a_base[`SOC_ROW_AW+3:4];
      end
      st_load_b: begin
        row.en       = 1'b1;
        row.row_addr = b_base[`SOC_ROW_AW+3:4];
      end
      st_compute: begin
        row.en       = 1'b1;
        row.we       = '1;
        row.row_addr = c_base[`SOC_ROW_AW+3:4] + `SOC_ROW_AW'(row_idx);
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (cfg_rd) begin
      case (reg_sel)
        reg_status: cfg.rd_data <= {{(`SOC_DATA_W-2){1'b0}}, done, busy};
        reg_a_base: cfg.rd_data <= a_base;
        reg_b_base: cfg.rd_data <= b_base;
        reg_c_base: cfg.rd_data <= c_base;
        default:    cfg.rd_data <= '0;  // Ctrl reads back as zero
      endcase
    end
  end

  a_irq_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    irq |=> !irq)
    else $error("irq held high for more than one cycle");

  a_row_en_busy: assert property (@(posedge clk) disable iff (!rst_n)
    row.en |-> busy)
    else $error("Row port enabled while the engine is idle");

endmodule

/* design/gemm_soc.sv */
`timescale 1ns/1ps
`include "soc_defs.svh"

module gemm_soc (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   bus_en,
  input  logic                   bus_rdwr,
  input  logic [`SOC_MASK_W-1:0] bus_mask,
  input  logic [`SOC_ADDR_W-1:0] bus_addr,
  input  logic [`SOC_DATA_W-1:0] bus_wr_data,
  output logic [`SOC_DATA_W-1:0] bus_rd_data,
  output logic                   bus_rd_valid,
  output logic                   irq
);

  sys_bus_if  mem_bus ();
  sys_bus_if  gemm_bus ();
  row_port_if row_port ();

  bus_decoder i_bus_decoder (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_en       (bus_en),
    .bus_rdwr     (bus_rdwr),
    .bus_mask     (bus_mask),
    .bus_addr     (bus_addr),
    .bus_wr_data  (bus_wr_data),
    .bus_rd_data  (bus_rd_data),
    .bus_rd_valid (bus_rd_valid),
    .mem_bus      (mem_bus),
    .gemm_bus     (gemm_bus)
  );

  banked_memory i_banked_memory (
    .clk  (clk),
    .host (mem_bus),
    .row  (row_port)
  );

  gemm_engine i_gemm_engine (
    .clk   (clk),
    .rst_n (rst_n),
    .cfg   (gemm_bus),
    .row   (row_port),
    .irq   (irq)
  );

endmodule

/* verif/gemm_soc_tb.sv */
`timescale 1ns/1ps
`include "soc_defs.svh"

module gemm_soc_tb import gemm_pkg::*; ();

  localparam int          TIMEOUT   = 50;
  localparam logic [31:0] GEMM_BASE = {`SOC_GEMM_REGION, 28'h0};
  localparam logic [31:0] SCRATCH   = 32'h0000_0200;
  localparam logic [31:0] A_ADDR    = 32'h0000_1000;
  localparam logic [31:0] B_ADDR    = 32'h0000_1010;
  localparam logic [31:0] C_ADDR    = 32'h0000_1100;

  logic                   clk;
  logic                   rst_n;
  logic                   bus_en;
  logic                   bus_rdwr;
  logic [`SOC_MASK_W-1:0] bus_mask;
  logic [`SOC_ADDR_W-1:0] bus_addr;
  logic [`SOC_DATA_W-1:0] bus_wr_data;
  logic [`SOC_DATA_W-1:0] bus_rd_data;
  logic                   bus_rd_valid;
  logic                   irq;

  int          value_errors;
  int          protocol_errors;
  int          timeout_errors;
  int          irq_count;
  logic [31:0] shadow [16];
  byte         a_ref [4][4];
  byte         b_ref [4][4];
  int          c_ref [4][4];

  gemm_soc i_gemm_soc (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_en       (bus_en),
    .bus_rdwr     (bus_rdwr),
    .bus_mask     (bus_mask),
    .bus_addr     (bus_addr),
    .bus_wr_data  (bus_wr_data),
    .bus_rd_data  (bus_rd_data),
    .bus_rd_valid (bus_rd_valid),
    .irq          (irq)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    if (irq) begin
      irq_count++;
    end
  end

  a_valid_follows_read: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_en && !bus_rdwr) |=> bus_rd_valid)
    else begin
      protocol_errors++;
      $display("bus_rd_valid did not follow a read request by one cycle");
    end

  a_valid_needs_read: assert property (@(posedge clk) disable iff (!rst_n)
    bus_rd_valid |-> $past(bus_en && !bus_rdwr))
    else begin
      protocol_errors++;
      $display("bus_rd_valid came up without a read request");
    end

  a_irq_single: assert property (@(posedge clk) disable iff (!rst_n) irq |=> !irq)
    else begin
      protocol_errors++;
      $display("irq stayed high for more than one cycle");
    end

  // All bus tasks start and end 1 ns after a rising edge
  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] mask);
    bus_en      = 1'b1;
    bus_rdwr    = 1'b1;
    bus_mask    = mask;
    bus_addr    = addr;
    bus_wr_data = data;
    @(posedge clk);
    #1;
    bus_en   = 1'b0;
    bus_rdwr = 1'b0;
  endtask

  task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
    int cycles;
    bus_en   = 1'b1;
    bus_rdwr = 1'b0;
    bus_mask = 4'hF;
    bus_addr = addr;
    @(posedge clk);
    #1;
    bus_en = 1'b0;
    cycles = 0;
    while (!bus_rd_valid && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!bus_rd_valid) begin
      timeout_errors++;
      $display("Timed out waiting for read data from address %h", addr);
    end
    data = bus_rd_data;
  endtask

  task automatic compare_word(input logic [31:0] addr, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp)
      else begin
        value_errors++;
        $display("Mismatch bus_rd_data at %h: got %h, expected %h", addr, got, exp);
      end
  endtask

  task automatic wait_for_irq();
    int cycles;
    cycles = 0;
    while (!irq && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!irq) begin
      timeout_errors++;
      $display("Timed out waiting for irq from the matrix engine");
    end
  endtask

  // Row i of A sits in word i of its memory row, element j in byte j
  task automatic load_operands();
    logic [31:0] a_word;
    logic [31:0] b_word;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        a_ref[i][j]       = byte'($urandom);
        b_ref[i][j]       = byte'($urandom);
        a_word[8*j +: 8] = a_ref[i][j];
        b_word[8*j +: 8] = b_ref[i][j];
      end
      write_word(A_ADDR + 4*i, a_word, 4'hF);
      write_word(B_ADDR + 4*i, b_word, 4'hF);
    end
  endtask

  function automatic void reference_product();
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        c_ref[i][j] = 0;
        for (int k = 0; k < 4; k++) begin
          c_ref[i][j] += int'(a_ref[i][k]) * int'(b_ref[k][j]);
        end
      end
    end
  endfunction

  task automatic check_product();
    logic [31:0] data;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        read_word(C_ADDR + 16*i + 4*j, data);
        compare_word(C_ADDR + 16*i + 4*j, data, c_ref[i][j]);
      end
    end
  endtask

  task automatic check_irq_count(input int exp);
    assert (irq_count == exp)
      else begin
        value_errors++;
        $display("Mismatch irq pulse count: got %h, expected %h", irq_count, exp);
      end
  endtask

  initial begin
    logic [31:0] data;
    logic [31:0] wdata;
    logic [31:0] cfg_vals [3];
    logic [3:0]  mask;
    int          w;
    void'($urandom(12));
    rst_n           = 1'b0;
    bus_en          = 1'b0;
    bus_rdwr        = 1'b0;
    bus_mask        = '0;
    bus_addr        = '0;
    bus_wr_data     = '0;
    value_errors    = 0;
    protocol_errors = 0;
    timeout_errors  = 0;
    irq_count       = 0;

    repeat (16) begin
      @(posedge clk);
      #1;
      assert (!irq && !bus_rd_valid)
        else begin
          protocol_errors++;
          $display("irq or bus_rd_valid high while reset is asserted");
        end
    end
    rst_n = 1'b1;

    read_word(GEMM_BASE | reg_status, data);
    compare_word(GEMM_BASE | reg_status, data, 32'h0);
    read_word(GEMM_BASE | reg_a_base, data);
    compare_word(GEMM_BASE | reg_a_base, data, 32'h0);

    for (int n = 0; n < 16; n++) begin
      shadow[n] = $urandom;
      write_word(SCRATCH + 4*n, shadow[n], 4'hF);
    end
    for (int n = 0; n < 48; n++) begin
      w     = $urandom_range(15, 0);
      mask  = 4'($urandom);
      wdata = $urandom;
      write_word(SCRATCH + 4*w, wdata, mask);
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
          shadow[w][8*b +: 8] = wdata[8*b +: 8];
        end
      end
      read_word(SCRATCH + 4*w, data);
      compare_word(SCRATCH + 4*w, data, shadow[w]);
    end

    for (int r = 0; r < 3; r++) begin
      cfg_vals[r] = $urandom;
    end
    write_word(GEMM_BASE | reg_a_base, cfg_vals[0], 4'hF);
    write_word(GEMM_BASE | reg_b_base, cfg_vals[1], 4'hF);
    write_word(GEMM_BASE | reg_c_base, cfg_vals[2], 4'hF);
    read_word(GEMM_BASE | reg_a_base, data);
    compare_word(GEMM_BASE | reg_a_base, data, cfg_vals[0]);
    read_word(GEMM_BASE | reg_b_base, data);
    compare_word(GEMM_BASE | reg_b_base, data, cfg_vals[1]);
    read_word(GEMM_BASE | reg_c_base, data);
    compare_word(GEMM_BASE | reg_c_base, data, cfg_vals[2]);

    load_operands();
    reference_product();
    write_word(GEMM_BASE | reg_a_base, A_ADDR, 4'hF);
    write_word(GEMM_BASE | reg_b_base, B_ADDR, 4'hF);
    write_word(GEMM_BASE | reg_c_base, C_ADDR, 4'hF);
    check_irq_count(0);  // No irq since reset before the first start
    irq_count = 0;
    write_word(GEMM_BASE | reg_ctrl, 32'h1, 4'hF);
    wait_for_irq();
    @(posedge clk);  // Engine leaves finish and sets done here
    #1;
    read_word(GEMM_BASE | reg_status, data);
    compare_word(GEMM_BASE | reg_status, data, 32'h2);
    check_product();
    check_irq_count(1);

    load_operands();
    reference_product();
    irq_count = 0;
    write_word(GEMM_BASE | reg_ctrl, 32'h1, 4'hF);
    read_word(GEMM_BASE | reg_status, data);
    compare_word(GEMM_BASE | reg_status, data, 32'h1);  // Busy, done cleared by the start
    write_word(GEMM_BASE | reg_ctrl, 32'h1, 4'hF);
    wait_for_irq();
    @(posedge clk);
    #1;
    read_word(GEMM_BASE | reg_status, data);
    compare_word(GEMM_BASE | reg_status, data, 32'h2);
    check_product();
    check_irq_count(1);

    $display("Errors: %0d value, %0d protocol, %0d timeout",
             value_errors, protocol_errors, timeout_errors);
    if (value_errors + protocol_errors + timeout_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+design
design/soc_bus_pkg.sv
design/gemm_pkg.sv
design/bus_ifs.sv
design/bus_decoder.sv
design/banked_memory.sv
design/gemm_engine.sv
design/gemm_soc.sv
verif/gemm_soc_tb.sv
